// File: bench/tb_frontend.sv
/*
 * testbench for the fetch frontend
 * clock, reset, instruction memory model, pc reference model, checks, watchdog
 */

`timescale 1ns/10ps
`default_nettype none

`include "frontend_defines.svh"

module tb_frontend import frontend_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int MEM_WORDS  = 256;
    localparam logic [31:0] SEED = 32'h5fbc_4b4c;
    localparam logic [`FE_XLEN-1:0] BOOT_ADDR = 32'h0000_0100;
    // redirect targets all land inside the looping test program
    localparam logic [`FE_XLEN-1:0] TRAP_ADDR = 32'h0000_0108;
    localparam logic [`FE_XLEN-1:0] EPC_ADDR  = 32'h0000_011c;
    localparam logic [`FE_XLEN-1:0] MIS_ADDR  = 32'h0000_0148;
    localparam int N_SEQ      = 8;
    localparam int N_PRED     = 32;
    localparam int N_BP       = 60;
    localparam int N_AFTER    = 10;
    localparam int N_REDIRECT = 7;
    // per-entry budget sized for the longest back-pressure stretches
    localparam int WATCHDOG_CYCLES =
        16 * (N_SEQ + N_PRED + N_BP + N_REDIRECT * N_AFTER) + 12 * N_REDIRECT + 200;

    logic                clk_i = 1'b0;
    logic                rst_ni;
    logic [`FE_XLEN-1:0] boot_addr;
    bp_resolve_t         resolved_branch;
    logic                ex_valid;
    logic [`FE_XLEN-1:0] trap_vector_base;
    logic                eret;
    logic [`FE_XLEN-1:0] epc;
    fetch_req_t          fetch_req;
    fetch_rsp_t          mem_rsp;
    fetch_entry_t        fetch_entry;
    logic                fetch_entry_valid;
    logic                fetch_entry_ready;

    // program image and the expected decode of every word
    logic [`FE_XLEN-1:0] mem [MEM_WORDS];
    logic [1:0]          exp_cf [MEM_WORDS];
    logic                exp_taken [MEM_WORDS];
    logic [`FE_XLEN-1:0] exp_next [MEM_WORDS];

    logic [`FE_XLEN-1:0] exp_pc;
    logic [`FE_XLEN-1:0] mem_addr = '0;
    logic                mem_accept = 1'b0;
    logic                released = 1'b0;
    logic                first_req_seen = 1'b0;
    int                  delivered = 0;
    string               test_name;

    frontend_top uut (
        .clk_i               ( clk_i             ),
        .rst_ni              ( rst_ni            ),
        .boot_addr_i         ( boot_addr         ),
        .resolved_branch_i   ( resolved_branch   ),
        .ex_valid_i          ( ex_valid          ),
        .trap_vector_base_i  ( trap_vector_base  ),
        .eret_i              ( eret              ),
        .epc_i               ( epc               ),
        .fetch_req_o         ( fetch_req         ),
        .fetch_rsp_i         ( mem_rsp           ),
        .fetch_entry_o       ( fetch_entry       ),
        .fetch_entry_valid_o ( fetch_entry_valid ),
        .fetch_entry_ready_i ( fetch_entry_ready )
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ---------------------------------------------------------------------
    // program image helpers
    // ---------------------------------------------------------------------
    // op-imm filler whose upper bits fold in the whole address
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        fill_word = {a[31:7] ^ a[24:0], 7'b0010011};
    endfunction

    // beq x0, x0, off
    function automatic logic [31:0] encode_branch(input logic [31:0] off);
        encode_branch = {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11],
                         7'b1100011};
    endfunction

    // jal x1, off
    function automatic logic [31:0] encode_jal(input logic [31:0] off);
        encode_jal = {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
    endfunction

    task automatic place_word(input logic [31:0] addr, input logic [31:0] word,
                              input cf_e cf, input logic taken, input logic [31:0] next_pc);
        mem[addr[9:2]]       = word;
        exp_cf[addr[9:2]]    = cf;
        exp_taken[addr[9:2]] = taken;
        exp_next[addr[9:2]]  = next_pc;
    endtask

    // loop over 0x104..0x14c with a forward branch, jalr, jal and a backward branch
    task automatic build_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            place_word(32'(i * 4), fill_word(32'(i * 4)), CF_NONE, 1'b0, 32'(i * 4 + 4));
        end
        place_word(32'h120, encode_branch(32'd16), CF_BRANCH, 1'b0, 32'h124);
        place_word(32'h124, 32'h0000_80e7, CF_JUMPR, 1'b0, 32'h128);
        place_word(32'h128, encode_jal(32'h20), CF_JUMP, 1'b1, 32'h148);
        place_word(32'h14c, encode_branch(-32'sd72), CF_BRANCH, 1'b1, 32'h104);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("** Error %s: %s expected %h actual %h", test_name, what, expected,
                     actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic wait_entries(input int n);
        int target;
        target = delivered + n;
        while (delivered < target) @(posedge clk_i);
    endtask

    // ---------------------------------------------------------------------
    // instruction memory answering one cycle after acceptance
    // ---------------------------------------------------------------------
    always @(posedge clk_i) begin
        mem_rsp.ready <= ($urandom_range(0, 3) != 0);
        mem_rsp.valid <= mem_accept;
        mem_rsp.data  <= mem_accept ? mem[mem_addr[9:2]] : '0;
    end

    // ---------------------------------------------------------------------
    // checker and reference pc model sampled mid-cycle
    // ---------------------------------------------------------------------
    always @(negedge clk_i) begin
        if (!rst_ni || !released) begin
            // reset and the boot cycle after it stay quiet
            check_value("req", 32'd0, 32'(fetch_req.req));
            check_value("entry valid", 32'd0, 32'(fetch_entry_valid));
            exp_pc = BOOT_ADDR;
            released = rst_ni;
        end else begin
            if (fetch_req.req && !first_req_seen) begin
                check_value("first request addr", boot_addr, fetch_req.addr);
                first_req_seen = 1'b1;
            end
            if (fetch_entry_valid && fetch_entry_ready) begin
                check_value("pc", exp_pc, fetch_entry.pc);
                check_value("instr", mem[exp_pc[9:2]], fetch_entry.instr);
                check_value("cf", 32'(exp_cf[exp_pc[9:2]]), 32'(fetch_entry.cf));
                check_value("taken", 32'(exp_taken[exp_pc[9:2]]), 32'(fetch_entry.taken));
                check_value("target", exp_next[exp_pc[9:2]], fetch_entry.target);
                exp_pc = exp_next[exp_pc[9:2]];
                delivered++;
            end
            // restart the expected stream at the highest priority source
            if (ex_valid) begin
                exp_pc = trap_vector_base;
            end else if (eret) begin
                exp_pc = epc;
            end else if (resolved_branch.valid && resolved_branch.is_mispredict) begin
                exp_pc = resolved_branch.target;
            end
        end
        mem_accept = fetch_req.req & mem_rsp.ready;
        mem_addr   = fetch_req.addr;
    end

    // ---------------------------------------------------------------------
    // stimulus
    // ---------------------------------------------------------------------
    initial begin
        int low_len;
        int high_len;
        int target;
        void'($urandom(SEED));
        build_program();
        rst_ni            = 1'b0;
        boot_addr         = BOOT_ADDR;
        resolved_branch   = '0;
        ex_valid          = 1'b0;
        trap_vector_base  = TRAP_ADDR;
        eret              = 1'b0;
        epc               = EPC_ADDR;
        mem_rsp           = '0;
        fetch_entry_ready = 1'b0;
        test_name         = "reset_boot";
        repeat (5) @(posedge clk_i);
        rst_ni            <= 1'b1;
        fetch_entry_ready <= 1'b1;
        while (!first_req_seen) @(posedge clk_i);

        test_name = "sequential";
        wait_entries(N_SEQ);
        // loop body covers forward branch, jalr, jal and backward branch
        test_name = "prediction";
        wait_entries(N_PRED);

        test_name = "backpressure";
        target = delivered + N_BP;
        while (delivered < target) begin
            low_len  = $urandom_range(1, 12);
            high_len = $urandom_range(1, 4);
            fetch_entry_ready <= 1'b0;
            repeat (low_len) @(posedge clk_i);
            fetch_entry_ready <= 1'b1;
            repeat (high_len) @(posedge clk_i);
        end

        // every combination of mispredict, eret and exception
        for (int combo = 1; combo <= N_REDIRECT; combo++) begin
            test_name = $sformatf("redirect ex%0d eret%0d mis%0d", combo[2], combo[1],
                                  combo[0]);
            fetch_entry_ready <= 1'b1;
            repeat ($urandom_range(2, 9)) @(posedge clk_i);
            ex_valid                      <= combo[2];
            eret                          <= combo[1];
            resolved_branch.valid         <= combo[0];
            resolved_branch.is_mispredict <= combo[0];
            resolved_branch.target        <= MIS_ADDR;
            // decode holds off while the queue is flushed
            fetch_entry_ready             <= 1'b0;
            @(posedge clk_i);
            ex_valid                      <= 1'b0;
            eret                          <= 1'b0;
            resolved_branch.valid         <= 1'b0;
            resolved_branch.is_mispredict <= 1'b0;
            fetch_entry_ready             <= 1'b1;
            wait_entries(N_AFTER);
        end

        repeat (4) @(posedge clk_i);
        $display("TEST OK");
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the frontend stopped delivering entries");
        $display("TEST FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+verilog
verilog/frontend_pkg.sv
verilog/instr_scan.sv
verilog/pc_gen.sv
verilog/fetch_queue.sv
verilog/frontend_top.sv
bench/tb_frontend.sv

// File: run.sh
#!/bin/sh
# build the fetch frontend testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_frontend \
    -Mdir obj_dir -o tb_frontend
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_frontend)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TEST OK$"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: verilog/fetch_queue.sv
/*
 * circular fetch queue towards decode
 * register array, count based full, registered valid output, flush
 */

`timescale 1ns/10ps
`default_nettype none

`include "frontend_defines.svh"

module fetch_queue import frontend_pkg::*; #(
    parameter int unsigned DEPTH = `FE_QUEUE_DEPTH
) (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         flush_i,
    input  logic         push_i,
    input  fetch_entry_t entry_i,
    input  logic         fetch_entry_ready_i,
    output logic         full_o,
    output fetch_entry_t fetch_entry_o,
    output logic         fetch_entry_valid_o
);

    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;

    fetch_entry_t mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_d, count_q;
    // mirrors count_q != 0 so decode sees a flop
    logic             valid_q;
    logic             push_ok;
    logic             pop;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign push_ok = push_i & ~full_o;
    assign pop     = valid_q & fetch_entry_ready_i;

    // head entry straight from the array
    assign fetch_entry_o       = mem_q[rd_ptr_q];
    assign fetch_entry_valid_o = valid_q;

    // ---------------------------------------------------------------------
    // occupancy
    // ---------------------------------------------------------------------
    always_comb begin
        count_d = count_q;
        if (push_ok && !pop) count_d = count_q + CNT_W'(1);
        if (!push_ok && pop) count_d = count_q - CNT_W'(1);
        if (flush_i) count_d = '0;
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            valid_q  <= 1'b0;
        end else begin
            count_q <= count_d;
            valid_q <= (count_d != '0);
            if (flush_i) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
            end else begin
                if (push_ok) wr_ptr_q <= wr_ptr_q + PTR_W'(1);
                if (pop) rd_ptr_q <= rd_ptr_q + PTR_W'(1);
            end
        end
    end

    // ---------------------------------------------------------------------
    // storage
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (push_ok) mem_q[wr_ptr_q] <= entry_i;
    end

endmodule

`default_nettype wire

// File: verilog/frontend_defines.svh
/*
 * fetch frontend configuration macros
 * word width, fetch queue depth and sequential pc step
 */

`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

// ---------------------------------------------------------------------
// datapath widths
// ---------------------------------------------------------------------
// address and instruction width, one word
`define FE_XLEN 32

// ---------------------------------------------------------------------
// fetch queue and pc step
// ---------------------------------------------------------------------
// entries held between fetch and decode, keep it a power of two
`define FE_QUEUE_DEPTH 4
// byte step between two sequential uncompressed instructions
`define FE_INSTR_BYTES 4

`endif

// File: verilog/frontend_pkg.sv
/*
 * shared types of the fetch frontend
 * opcode and control-flow enums, memory, scan, resolve and queue structs
 */

`default_nettype none

`include "frontend_defines.svh"

package frontend_pkg;

    // ---------------------------------------------------------------------
    // encodings
    // ---------------------------------------------------------------------
    // major opcodes the scan looks for, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // control-flow class of one fetched instruction
    typedef enum logic [1:0] {
        CF_NONE,
        CF_BRANCH,
        CF_JUMP,
        CF_JUMPR
    } cf_e;

    // ---------------------------------------------------------------------
    // structs passed between modules
    // ---------------------------------------------------------------------
    typedef struct packed {
        cf_e                 cf;
        logic [`FE_XLEN-1:0] imm;
    } scan_t;

    // request strobe plus word address towards the instruction memory
    typedef struct packed {
        logic                req;
        logic [`FE_XLEN-1:0] addr;
    } fetch_req_t;

    // ready is a level, valid pulses one cycle after acceptance
    typedef struct packed {
        logic                ready;
        logic                valid;
        logic [`FE_XLEN-1:0] data;
    } fetch_rsp_t;

    typedef struct packed {
        logic                valid;
        logic                is_mispredict;
        logic [`FE_XLEN-1:0] target;
    } bp_resolve_t;

    // one instruction handed to decode
    typedef struct packed {
        logic [`FE_XLEN-1:0] pc;
        logic [`FE_XLEN-1:0] instr;
        cf_e                 cf;
        logic                taken;
        logic [`FE_XLEN-1:0] target;
    } fetch_entry_t;

endpackage

`default_nettype wire

// File: verilog/frontend_top.sv
/*
 * fetch frontend top level
 * pc generator, instruction scan and fetch queue
 */

`timescale 1ns/10ps
`default_nettype none

`include "frontend_defines.svh"

module frontend_top import frontend_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic [`FE_XLEN-1:0] boot_addr_i,
    // redirects from the backend
    input  bp_resolve_t         resolved_branch_i,
    input  logic                ex_valid_i,
    input  logic [`FE_XLEN-1:0] trap_vector_base_i,
    input  logic                eret_i,
    input  logic [`FE_XLEN-1:0] epc_i,
    // instruction memory
    output fetch_req_t          fetch_req_o,
    input  fetch_rsp_t          fetch_rsp_i,
    // decode side
    output fetch_entry_t        fetch_entry_o,
    output logic                fetch_entry_valid_o,
    input  logic                fetch_entry_ready_i
);

    logic [`FE_XLEN-1:0] scan_instr;
    scan_t               scan;
    logic                push;
    fetch_entry_t        entry;
    logic                flush;
    logic                queue_full;

    // ---------------------------------------------------------------------
    // pc generation and memory request
    // ---------------------------------------------------------------------
    pc_gen i_pc_gen (
        .clk_i              ( clk_i              ),
        .rst_ni             ( rst_ni             ),
        .boot_addr_i        ( boot_addr_i        ),
        .resolved_branch_i  ( resolved_branch_i  ),
        .ex_valid_i         ( ex_valid_i         ),
        .trap_vector_base_i ( trap_vector_base_i ),
        .eret_i             ( eret_i             ),
        .epc_i              ( epc_i              ),
        .fetch_rsp_i        ( fetch_rsp_i        ),
        .scan_i             ( scan               ),
        .queue_full_i       ( queue_full         ),
        .fetch_req_o        ( fetch_req_o        ),
        .scan_instr_o       ( scan_instr         ),
        .push_o             ( push               ),
        .entry_o            ( entry              ),
        .flush_o            ( flush              )
    );

    // scan sits on the raw response data
    instr_scan i_instr_scan (
        .instr_i ( scan_instr ),
        .scan_o  ( scan       )
    );

    // ---------------------------------------------------------------------
    // queue towards decode
    // ---------------------------------------------------------------------
    fetch_queue #(
        .DEPTH ( `FE_QUEUE_DEPTH )
    ) i_fetch_queue (
        .clk_i               ( clk_i               ),
        .rst_ni              ( rst_ni              ),
        .flush_i             ( flush               ),
        .push_i              ( push                ),
        .entry_i             ( entry               ),
        .fetch_entry_ready_i ( fetch_entry_ready_i ),
        .full_o              ( queue_full          ),
        .fetch_entry_o       ( fetch_entry_o       ),
        .fetch_entry_valid_o ( fetch_entry_valid_o )
    );

endmodule

`default_nettype wire

// File: verilog/instr_scan.sv
/*
 * instruction scan for uncompressed instructions
 * classifies branch, jal and jalr and extracts their immediates
 */

`timescale 1ns/10ps
`default_nettype none

`include "frontend_defines.svh"

module instr_scan import frontend_pkg::*; (
    input  logic [`FE_XLEN-1:0] instr_i,
    output scan_t               scan_o
);

    // major opcode field
    logic [6:0]          opcode;
    // sign-extended immediates, both with bit 0 forced to zero
    logic [`FE_XLEN-1:0] imm_b;
    logic [`FE_XLEN-1:0] imm_j;

    assign opcode = instr_i[6:0];

    // b-type: imm[12|10:5] in [31:25], imm[4:1|11] in [11:7]
    assign imm_b = {{(`FE_XLEN-12){instr_i[31]}},
                    instr_i[7],
                    instr_i[30:25],
                    instr_i[11:8],
                    1'b0};

    // j-type: imm[20|10:1|11|19:12] in [31:12]
    assign imm_j = {{(`FE_XLEN-20){instr_i[31]}},
                    instr_i[19:12],
                    instr_i[20],
                    instr_i[30:21],
                    1'b0};

    // ---------------------------------------------------------------------
    // classification
    // ---------------------------------------------------------------------
    always_comb begin
        scan_o.cf  = CF_NONE;
        scan_o.imm = '0;
        case (opcode)
            OPC_BRANCH: begin
                scan_o.cf  = CF_BRANCH;
                scan_o.imm = imm_b;
            end
            OPC_JAL: begin
                scan_o.cf  = CF_JUMP;
                scan_o.imm = imm_j;
            end
            // target depends on a register, nothing to predict here
            OPC_JALR: begin
                scan_o.cf = CF_JUMPR;
            end
            default: begin
                scan_o.cf  = CF_NONE;
                scan_o.imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/pc_gen.sv
/*
 * pc generation: next-pc register, redirect priority, static prediction
 * and the single outstanding request towards instruction memory
 */

`timescale 1ns/10ps
`default_nettype none

`include "frontend_defines.svh"

module pc_gen import frontend_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic [`FE_XLEN-1:0] boot_addr_i,
    input  bp_resolve_t         resolved_branch_i,
    input  logic                ex_valid_i,
    input  logic [`FE_XLEN-1:0] trap_vector_base_i,
    input  logic                eret_i,
    input  logic [`FE_XLEN-1:0] epc_i,
    input  fetch_rsp_t          fetch_rsp_i,
    input  scan_t               scan_i,
    input  logic                queue_full_i,
    output fetch_req_t          fetch_req_o,
    output logic [`FE_XLEN-1:0] scan_instr_o,
    output logic                push_o,
    output fetch_entry_t        entry_o,
    output logic                flush_o
);

    logic [`FE_XLEN-1:0] npc_d, npc_q;
    // high in reset and the first cycle after, loads boot_addr_i
    logic                boot_q;
    // a request was accepted and its response is due this cycle
    logic                outstanding_q;
    // the due response belongs to a path killed by a redirect
    logic                discard_q;
    logic [`FE_XLEN-1:0] req_addr_q;

    logic                req;
    logic                accept;
    logic                is_mispredict;
    logic                redirect;
    logic                rsp_keep;
    logic                predict_taken;
    logic [`FE_XLEN-1:0] predict_addr;
    logic [`FE_XLEN-1:0] seq_addr;

    // ---------------------------------------------------------------------
    // memory request
    // ---------------------------------------------------------------------
    // one request in flight at most, and only with room in the queue
    assign req                = ~boot_q & ~outstanding_q & ~queue_full_i;
    assign accept             = req & fetch_rsp_i.ready;
    assign fetch_req_o.req    = req;
    assign fetch_req_o.addr   = npc_q;

    assign is_mispredict = resolved_branch_i.valid & resolved_branch_i.is_mispredict;
    assign redirect      = ex_valid_i | eret_i | is_mispredict;
    assign flush_o       = redirect;

    // ---------------------------------------------------------------------
    // response and static prediction
    // ---------------------------------------------------------------------
    assign scan_instr_o = fetch_rsp_i.data;
    assign rsp_keep     = fetch_rsp_i.valid & outstanding_q & ~discard_q & ~redirect;

    // jal always taken, branches only when pointing backwards
    assign predict_taken = (scan_i.cf == CF_JUMP) |
                           ((scan_i.cf == CF_BRANCH) & scan_i.imm[`FE_XLEN-1]);
    assign predict_addr  = req_addr_q + scan_i.imm;
    assign seq_addr      = req_addr_q + `FE_XLEN'(`FE_INSTR_BYTES);

    assign push_o        = rsp_keep;
    assign entry_o.pc    = req_addr_q;
    assign entry_o.instr = fetch_rsp_i.data;
    assign entry_o.cf    = scan_i.cf;
    assign entry_o.taken = predict_taken;
    // predicted next fetch address of this entry
    assign entry_o.target = predict_taken ? predict_addr : seq_addr;

    // ---------------------------------------------------------------------
    // next pc, lowest priority first
    // ---------------------------------------------------------------------
    always_comb begin
        npc_d = npc_q;
        if (boot_q) npc_d = boot_addr_i;
        if (accept) npc_d = npc_q + `FE_XLEN'(`FE_INSTR_BYTES);
        if (rsp_keep && predict_taken) npc_d = predict_addr;
        if (is_mispredict) npc_d = resolved_branch_i.target;
        if (eret_i) npc_d = epc_i;
        if (ex_valid_i) npc_d = trap_vector_base_i;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_q         <= '0;
            boot_q        <= 1'b1;
            outstanding_q <= 1'b0;
            discard_q     <= 1'b0;
        end else begin
            npc_q  <= npc_d;
            boot_q <= 1'b0;
            // response comes exactly one cycle after acceptance
            if (accept) begin
                outstanding_q <= 1'b1;
                discard_q     <= redirect;
            end else if (fetch_rsp_i.valid) begin
                outstanding_q <= 1'b0;
                discard_q     <= 1'b0;
            end
        end
    end

    // address of the request in flight
    always_ff @(posedge clk_i) begin
        if (accept) req_addr_q <= npc_q;
    end

endmodule

`default_nettype wire
